//--- compile.f
design/regf_pkg.sv
design/regf_storage.sv
design/hdr_desc_decode.sv
design/regf_status_regs.sv
design/reg_file_top.sv
test/tb_reg_file.sv

//--- design/hdr_desc_decode.sv
////////////////////////////////////////
// Registered HDR command descriptor decode
// Output lags the window by one clock
// cmd_attr bit 0 selects immediate or regular layout
////////////////////////////////////////
`default_nettype none

module hdr_desc_decode (
  input  wire                         i_regf_clk,
  input  wire                         i_regf_rst_n,
  input  wire regf_pkg::desc_window_t i_desc_window,
  output regf_pkg::hdr_cmd_t          o_hdr_cmd
);
  import regf_pkg::*;

  logic [31:0] dw0;        // Descriptor word 0
  logic [31:0] dw1;        // Descriptor word 1
  logic        immediate;  // Immediate layout
  hdr_cmd_t    cmd_d;      // Next decoded command

  assign dw0       = i_desc_window.dword0;
  assign dw1       = i_desc_window.dword1;
  assign immediate = dw0[0];

  ////////////////////////////////////////
  // Field map
  ////////////////////////////////////////
  always_comb
  begin
    cmd_d.data_len  = dw1[31:16];
    cmd_d.cmd_attr  = dw0[2:0];
    cmd_d.tid       = dw0[6:3];
    cmd_d.ccc       = dw0[14:7];
    cmd_d.cp        = dw0[15];
    cmd_d.dev_index = dw0[20:16];
    cmd_d.mode      = dw0[28:26];
    cmd_d.rnw       = dw0[29];
    cmd_d.wroc      = dw0[30];
    cmd_d.toc       = dw0[31];
    // Bits 25:23 mean different things per layout
    if (immediate)
    begin
      cmd_d.dtt = dw0[25:23];  // Data byte count
      cmd_d.dbp = 1'b0;
      cmd_d.sre = 1'b0;
    end
    else
    begin
      cmd_d.dtt = 3'd0;
      cmd_d.dbp = dw0[25];     // Defining byte present
      cmd_d.sre = dw0[24];     // Short read
    end
  end

  always_ff @(posedge i_regf_clk or negedge i_regf_rst_n)
  begin
    if (!i_regf_rst_n)
    begin
      o_hdr_cmd <= '0;
    end
    else
    begin
      o_hdr_cmd <= cmd_d;
    end
  end

  // Immediate descriptor seen last edge gives no DBP or SRE now
  a_imm_no_dbp_sre : assert property (
    @(posedge i_regf_clk) disable iff (!i_regf_rst_n)
      $past(i_desc_window.dword0[0]) |-> (!o_hdr_cmd.dbp && !o_hdr_cmd.sre)
  );

endmodule

`default_nettype wire

//--- design/reg_file_top.sv
////////////////////////////////////////
// Configuration register file of the I3C controller
// Host strobes are levels, no handshake
// i_engine_configuration plus 7 must stay in range
////////////////////////////////////////
`default_nettype none

module reg_file_top (
  input  wire                        i_regf_clk,
  input  wire                        i_regf_rst_n,     // Async, active low
  input  wire                        i_regf_rd_en,
  input  wire                        i_regf_wr_en,
  input  wire regf_pkg::regf_addr_t  i_regf_addr,
  input  wire regf_pkg::regf_byte_t  i_regf_data_wr,
  input  wire regf_pkg::regf_addr_t  i_engine_configuration,  // Descriptor base
  output regf_pkg::regf_byte_t       o_regf_data_rd,
  output regf_pkg::hdr_cmd_t         o_hdr_cmd,
  output regf_pkg::crh_regs_t        o_crh,
  output regf_pkg::ibi_regs_t        o_ibi,
  output regf_pkg::regf_byte_t       o_regf_num_frames,
  output logic                       o_ser_rx_tx,
  output logic [2:0]                 o_regf_hj_cfg,
  output logic                       o_regf_hj_support
);
  import regf_pkg::*;

  desc_window_t desc_window;  // Eight bytes at the base
  regf_fixed_t  fixed;        // Live fixed-location bytes
  logic         hj_enable;    // Hot-join enable rule

  ////////////////////////////////////////
  // Instances
  ////////////////////////////////////////
  regf_storage storage_i (
    .i_regf_clk     (i_regf_clk),
    .i_regf_rst_n   (i_regf_rst_n),
    .i_regf_rd_en   (i_regf_rd_en),
    .i_regf_wr_en   (i_regf_wr_en),
    .i_regf_addr    (i_regf_addr),
    .i_regf_data_wr (i_regf_data_wr),
    .i_desc_base    (i_engine_configuration),
    .i_hj_enable    (hj_enable),
    .o_regf_data_rd (o_regf_data_rd),
    .o_desc_window  (desc_window),
    .o_fixed        (fixed)
  );

  hdr_desc_decode decode_i (
    .i_regf_clk    (i_regf_clk),
    .i_regf_rst_n  (i_regf_rst_n),
    .i_desc_window (desc_window),
    .o_hdr_cmd     (o_hdr_cmd)
  );

  regf_status_regs status_i (
    .i_regf_clk        (i_regf_clk),
    .i_regf_rst_n      (i_regf_rst_n),
    .i_fixed           (fixed),
    .o_crh             (o_crh),
    .o_ibi             (o_ibi),
    .o_regf_num_frames (o_regf_num_frames),
    .o_ser_rx_tx       (o_ser_rx_tx),
    .o_regf_hj_cfg     (o_regf_hj_cfg),
    .o_regf_hj_support (o_regf_hj_support),
    .o_hj_enable       (hj_enable)           // Loops back into storage
  );

endmodule

`default_nettype wire

//--- design/regf_pkg.sv
////////////////////////////////////////
// Sizes, addresses and types shared by the register file
// Reset table is fixed, unlisted addresses reset to zero
// Byte order in the array is little endian for descriptor words
////////////////////////////////////////
`default_nettype none

package regf_pkg;

  ////////////////////////////////////////
  // Array geometry
  ////////////////////////////////////////
  localparam int REGF_WIDTH  = 8;    // One byte per entry
  localparam int REGF_DEPTH  = 512;  // Entry count
  localparam int REGF_ADDR_W = 9;    // Enough for REGF_DEPTH

  typedef logic [REGF_ADDR_W-1:0] regf_addr_t;
  typedef logic [REGF_WIDTH-1:0]  regf_byte_t;

  ////////////////////////////////////////
  // Fixed register locations
  ////////////////////////////////////////
  localparam regf_addr_t ADDR_TARGET        = 9'd0;    // Target address, bit 0 is RnW
  localparam regf_addr_t ADDR_NUM_FRAMES    = 9'd1;
  localparam regf_addr_t ADDR_TGTS_COUNT    = 9'd35;
  localparam regf_addr_t ADDR_ARBITRATION   = 9'd48;   // Arbitrated address for IBI
  localparam regf_addr_t ADDR_IBI_CFG       = 9'd101;
  localparam regf_addr_t ADDR_IBI_PAYLOAD   = 9'd102;  // Max payload size

  // Controller role handoff
  localparam regf_addr_t ADDR_CRHDLY        = 9'd383;
  localparam regf_addr_t ADDR_CRCAPS2       = 9'd386;
  localparam regf_addr_t ADDR_PRECR         = 9'd388;
  localparam regf_addr_t ADDR_GETSTATUS_LSB = 9'd390;
  localparam regf_addr_t ADDR_CRH_CFG       = 9'd407;

  // Hot-join
  localparam regf_addr_t ADDR_ENEC_BYTE     = 9'd402;  // Holds ENHJ
  localparam regf_addr_t ADDR_DISEC_BYTE    = 9'd404;  // Holds DISHJ
  localparam regf_addr_t ADDR_HJ_CFG        = 9'd405;
  localparam regf_addr_t ADDR_CRCAP1        = 9'd409;

  localparam regf_addr_t ADDR_DUMMY_DESC    = 9'd450;  // Base of the fixed dummy descriptor

  localparam int HJ_DEF_BIT = 3;  // ENHJ and DISHJ position

  ////////////////////////////////////////
  // Structs
  ////////////////////////////////////////
  // Eight descriptor bytes, dword1 on top so the lowest address lands in bits 7:0
  typedef struct packed {
    logic [31:0] dword1;
    logic [31:0] dword0;
  } desc_window_t;

  typedef struct packed {
    logic [15:0] data_len;
    logic [2:0]  cmd_attr;   // Bit 0 set means immediate
    logic [3:0]  tid;
    logic [7:0]  ccc;
    logic        cp;
    logic [4:0]  dev_index;
    logic [2:0]  dtt;        // Immediate only
    logic [2:0]  mode;
    logic        rnw;
    logic        wroc;
    logic        toc;
    logic        dbp;        // Regular only
    logic        sre;        // Regular only
  } hdr_cmd_t;

  typedef struct packed {
    regf_byte_t crhdly;
    regf_byte_t getstatus;
    regf_byte_t crcap2;
    regf_byte_t precr;
    regf_byte_t cfg;
    regf_byte_t tgts_count;
  } crh_regs_t;

  typedef struct packed {
    regf_byte_t cfg;
    regf_byte_t payload_size;
    regf_byte_t tgt_address;
  } ibi_regs_t;

  // Live bytes at fixed locations
  typedef struct packed {
    regf_byte_t target;
    regf_byte_t num_frames;
    crh_regs_t  crh;
    ibi_regs_t  ibi;
    regf_byte_t hj_cfg;
    regf_byte_t crcap1;
  } regf_fixed_t;

  ////////////////////////////////////////
  // Reset defaults
  ////////////////////////////////////////
  function automatic regf_byte_t regf_default(input regf_addr_t addr);
    regf_byte_t val;
    case (addr)
      ADDR_TARGET:       val = 8'hA8;  // Target 7'h54, write
      ADDR_NUM_FRAMES:   val = 8'h02;
      9'd2:              val = 8'h01;
      9'd3:              val = 8'h02;
      9'd4:              val = 8'h06;
      ADDR_TGTS_COUNT:   val = 8'h02;
      9'd46:             val = 8'hFC;  // Broadcast 7'h7E + W
      9'd47:             val = 8'hFD;  // Broadcast 7'h7E + R
      ADDR_ARBITRATION:  val = 8'h53;
      9'd49:             val = 8'h07;  // ENTDAA
      9'd50:             val = 8'h20;
      ADDR_IBI_CFG:      val = 8'h01;  // ACK + MDB
      ADDR_IBI_PAYLOAD:  val = 8'h03;
      9'd103:            val = 8'h81;  // DISEC direct
      9'd104:            val = 8'h01;  // DISEC broadcast
      9'd381:            val = 8'h94;  // GETMXDS
      9'd382:            val = 8'h91;  // Defining byte
      ADDR_CRHDLY:       val = 8'h02;
      9'd384:            val = 8'h95;  // GETCAPS
      ADDR_CRCAPS2:      val = 8'h02;
      9'd387:            val = 8'h90;  // GETSTATUS
      ADDR_PRECR:        val = 8'h02;
      9'd389:            val = 8'h91;  // GETACCCR
      ADDR_GETSTATUS_LSB: val = 8'h02;
      9'd392:            val = 8'h0B;  // Event disable byte
      9'd393:            val = 8'h02;  // ENTAS0..3
      9'd394:            val = 8'h03;
      9'd395:            val = 8'h04;
      9'd396:            val = 8'h05;
      9'd397:            val = 8'h08;  // DEFTGTS
      ADDR_ENEC_BYTE:    val = 8'h0B;  // ENINT, ENCR, ENHJ
      9'd403:            val = 8'h01;  // DISEC CCC
      ADDR_HJ_CFG:       val = 8'h07;
      9'd406:            val = 8'h09;  // Hot-join and interrupts off
      ADDR_CRH_CFG:      val = 8'h01;
      ADDR_DUMMY_DESC:   val = 8'h81;  // Dummy descriptor, immediate
      regf_addr_t'(ADDR_DUMMY_DESC + 1): val = 8'h8F;
      regf_addr_t'(ADDR_DUMMY_DESC + 3): val = 8'h18;
      default:           val = '0;     // ENEC CCC, DISEC byte and CRCAP1 included
    endcase
    return val;
  endfunction

endpackage

`default_nettype wire

//--- design/regf_status_regs.sv
////////////////////////////////////////
// Registered copies of fixed-location settings
// Copies lag the array by one clock
// Hot-join outputs are combinational
////////////////////////////////////////
`default_nettype none

module regf_status_regs (
  input  wire                        i_regf_clk,
  input  wire                        i_regf_rst_n,
  input  wire regf_pkg::regf_fixed_t i_fixed,
  output regf_pkg::crh_regs_t        o_crh,
  output regf_pkg::ibi_regs_t        o_ibi,
  output regf_pkg::regf_byte_t       o_regf_num_frames,
  output logic                       o_ser_rx_tx,        // Target RnW bit
  output logic [2:0]                 o_regf_hj_cfg,
  output logic                       o_regf_hj_support,
  output logic                       o_hj_enable         // Back to storage
);
  import regf_pkg::*;

  regf_byte_t hj_cfg_byte;  // HJ_CFG
  regf_byte_t crcap1_byte;  // CRCAP1

  assign hj_cfg_byte = i_fixed.hj_cfg;
  assign crcap1_byte = i_fixed.crcap1;

  ////////////////////////////////////////
  // Hot-join
  ////////////////////////////////////////
  assign o_regf_hj_cfg     = hj_cfg_byte[2:0];
  assign o_regf_hj_support = crcap1_byte[0];      // Controller supports hot-join

  // Supported and enabled by configuration
  assign o_hj_enable = crcap1_byte[0] & hj_cfg_byte[1];

  ////////////////////////////////////////
  // Registered copies
  ////////////////////////////////////////
  always_ff @(posedge i_regf_clk or negedge i_regf_rst_n)
  begin
    if (!i_regf_rst_n)
    begin
      o_crh             <= '0;
      o_ibi             <= '0;
      o_regf_num_frames <= '0;
      o_ser_rx_tx       <= 1'b0;
    end
    else
    begin
      o_crh             <= i_fixed.crh;
      o_ibi             <= i_fixed.ibi;
      o_regf_num_frames <= i_fixed.num_frames;
      o_ser_rx_tx       <= i_fixed.target[0];  // Direction for ACK phase
    end
  end

endmodule

`default_nettype wire

//--- design/regf_storage.sv
////////////////////////////////////////
// Byte array with reset defaults and one host port
// Read or write only when exactly one strobe is high
// Descriptor base plus 7 must stay inside the array
// ENHJ/DISHJ bits are owned by the hot-join rule
////////////////////////////////////////
`default_nettype none

module regf_storage (
  input  wire                        i_regf_clk,
  input  wire                        i_regf_rst_n,
  input  wire                        i_regf_rd_en,
  input  wire                        i_regf_wr_en,
  input  wire regf_pkg::regf_addr_t  i_regf_addr,
  input  wire regf_pkg::regf_byte_t  i_regf_data_wr,
  input  wire regf_pkg::regf_addr_t  i_desc_base,     // First descriptor byte
  input  wire                        i_hj_enable,     // From hot-join rule
  output regf_pkg::regf_byte_t       o_regf_data_rd,
  output regf_pkg::desc_window_t     o_desc_window,
  output regf_pkg::regf_fixed_t      o_fixed
);
  import regf_pkg::*;

  regf_byte_t mem [REGF_DEPTH];  // Configuration array
  logic       rd_only;           // Read strobe alone
  logic       wr_only;           // Write strobe alone

  // Both strobes together cancel each other
  assign rd_only = i_regf_rd_en & ~i_regf_wr_en;
  assign wr_only = i_regf_wr_en & ~i_regf_rd_en;

  ////////////////////////////////////////
  // Array update
  ////////////////////////////////////////
  always_ff @(posedge i_regf_clk or negedge i_regf_rst_n)
  begin
    if (!i_regf_rst_n)
    begin
      for (int i = 0; i < REGF_DEPTH; i++)
      begin
        mem[i] <= regf_default(regf_addr_t'(i));  // Load table
      end
    end
    else
    begin
      if (wr_only)
      begin
        mem[i_regf_addr] <= i_regf_data_wr;
      end
      // Hot-join defining bits, later assignment beats a host write
      mem[ADDR_ENEC_BYTE][HJ_DEF_BIT]  <= i_hj_enable;   // ENHJ
      mem[ADDR_DISEC_BYTE][HJ_DEF_BIT] <= ~i_hj_enable;  // DISHJ
    end
  end

  // Registered read, holds until the next read
  always_ff @(posedge i_regf_clk or negedge i_regf_rst_n)
  begin
    if (!i_regf_rst_n)
    begin
      o_regf_data_rd <= '0;
    end
    else if (rd_only)
    begin
      o_regf_data_rd <= mem[i_regf_addr];
    end
  end

  ////////////////////////////////////////
  // Descriptor window
  ////////////////////////////////////////
  // Four bytes per word, lowest address in the low byte
  always_comb
  begin
    for (int k = 0; k < 4; k++)
    begin
      o_desc_window.dword0[REGF_WIDTH*k +: REGF_WIDTH] =
        mem[i_desc_base + regf_addr_t'(k)];
      o_desc_window.dword1[REGF_WIDTH*k +: REGF_WIDTH] =
        mem[i_desc_base + regf_addr_t'(k + 4)];
    end
  end

  ////////////////////////////////////////
  // Fixed-location snapshot
  ////////////////////////////////////////
  always_comb
  begin
    o_fixed.target           = mem[ADDR_TARGET];
    o_fixed.num_frames       = mem[ADDR_NUM_FRAMES];
    // Controller role handoff group
    o_fixed.crh.crhdly       = mem[ADDR_CRHDLY];
    o_fixed.crh.getstatus    = mem[ADDR_GETSTATUS_LSB];
    o_fixed.crh.crcap2       = mem[ADDR_CRCAPS2];
    o_fixed.crh.precr        = mem[ADDR_PRECR];
    o_fixed.crh.cfg          = mem[ADDR_CRH_CFG];
    o_fixed.crh.tgts_count   = mem[ADDR_TGTS_COUNT];
    // IBI group
    o_fixed.ibi.cfg          = mem[ADDR_IBI_CFG];
    o_fixed.ibi.payload_size = mem[ADDR_IBI_PAYLOAD];
    o_fixed.ibi.tgt_address  = mem[ADDR_ARBITRATION];  // Arbitrated address
    // Hot-join inputs to the enable rule
    o_fixed.hj_cfg           = mem[ADDR_HJ_CFG];
    o_fixed.crcap1           = mem[ADDR_CRCAP1];
  end

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////
  // Engine must keep the whole descriptor inside the array
  a_desc_in_range : assert property (
    @(posedge i_regf_clk) disable iff (!i_regf_rst_n)
      (int'(i_desc_base) + 7) < REGF_DEPTH
  );

  // From the first cycle out of reset ENHJ and DISHJ never agree
  a_hj_bits_differ : assert property (
    @(posedge i_regf_clk) disable iff (!i_regf_rst_n)
      $past(i_regf_rst_n) |->
        (mem[ADDR_ENEC_BYTE][HJ_DEF_BIT] != mem[ADDR_DISEC_BYTE][HJ_DEF_BIT])
  );

endmodule

`default_nettype wire

//--- test/tb_reg_file.sv
////////////////////////////////////////
// Testbench for the register file top
// Inputs change on the falling edge only
// Expected values come from a mirror of the array
////////////////////////////////////////
`default_nettype none

module tb_reg_file;
  timeunit 1ns;
  timeprecision 100ps;
  import regf_pkg::*;

  localparam int CLK_PERIOD = 40;
  localparam int RST_CYCLES = 16;
  localparam int N_DEF      = 28;
  localparam int N_WRRD     = 64;
  localparam int N_COLL     = 4;
  localparam int N_DESC     = 8;
  localparam int N_STATUS   = 24;
  // Clock cycles per test
  localparam int OPS_RESET  = RST_CYCLES + 2 + 2*N_DEF + 1;
  localparam int OPS_WRRD   = 3*N_WRRD + 1;
  localparam int OPS_COLL   = 6*N_COLL + 1;
  localparam int OPS_DESC   = 10*(N_DESC + 1) + 1;
  localparam int OPS_STATUS = 3*N_STATUS + 1;
  localparam int OPS_HJ     = 4*8 + 1;
  localparam int OPS_TOTAL  = OPS_RESET + OPS_WRRD + OPS_COLL + OPS_DESC + OPS_STATUS + OPS_HJ;

  localparam regf_addr_t DEF_ADDRS [N_DEF] = '{
    ADDR_TARGET, ADDR_NUM_FRAMES, 9'd2, 9'd3, 9'd4, ADDR_TGTS_COUNT, 9'd46, 9'd47,
    ADDR_ARBITRATION, 9'd49, 9'd50, ADDR_IBI_CFG, ADDR_IBI_PAYLOAD, 9'd103, ADDR_CRHDLY,
    ADDR_CRCAPS2, ADDR_PRECR, ADDR_GETSTATUS_LSB, ADDR_CRH_CFG, ADDR_ENEC_BYTE,
    ADDR_DISEC_BYTE, ADDR_HJ_CFG, ADDR_CRCAP1, ADDR_DUMMY_DESC, 9'd451, 9'd453, 9'd300, 9'd511};
  localparam regf_addr_t STATUS_ADDRS [11] = '{
    ADDR_TARGET, ADDR_NUM_FRAMES, ADDR_CRHDLY, ADDR_GETSTATUS_LSB, ADDR_CRCAPS2, ADDR_PRECR,
    ADDR_CRH_CFG, ADDR_TGTS_COUNT, ADDR_IBI_CFG, ADDR_IBI_PAYLOAD, ADDR_ARBITRATION};

  logic        clk = 1'b0;
  logic        rst_n, rd_en, wr_en;
  regf_addr_t  addr, base;          // Host address, descriptor base
  regf_byte_t  data_wr, o_regf_data_rd, o_regf_num_frames;
  hdr_cmd_t    o_hdr_cmd;
  crh_regs_t   o_crh;
  ibi_regs_t   o_ibi;
  logic        o_ser_rx_tx, o_regf_hj_support;
  logic [2:0]  o_regf_hj_cfg;

  regf_byte_t  mirror [REGF_DEPTH];  // Scoreboard copy of the array
  logic [31:0] lfsr;
  string       test_name;
  logic        chk_rd, chk_cmd, chk_status, chk_hj;  // Armed for one rising edge
  regf_byte_t  exp_rd, last_rd;
  hdr_cmd_t    exp_cmd;
  logic [80:0] exp_status;          // CRH, IBI, frames, RnW
  logic [3:0]  exp_hj;              // HJ_CFG[2:0], support
  int          n_checks, n_errors, err_mark, tests_pass, tests_fail;

  always #(CLK_PERIOD/2) clk = ~clk;

  reg_file_top dut_i (
    .i_regf_clk (clk), .i_regf_rst_n (rst_n),
    .i_regf_rd_en (rd_en), .i_regf_wr_en (wr_en),
    .i_regf_addr (addr), .i_regf_data_wr (data_wr), .i_engine_configuration (base),
    .o_regf_data_rd (o_regf_data_rd), .o_hdr_cmd (o_hdr_cmd), .o_crh (o_crh), .o_ibi (o_ibi),
    .o_regf_num_frames (o_regf_num_frames), .o_ser_rx_tx (o_ser_rx_tx),
    .o_regf_hj_cfg (o_regf_hj_cfg), .o_regf_hj_support (o_regf_hj_support)
  );

  ////////////////////////////////////////
  // Model helpers
  ////////////////////////////////////////
  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      r    = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  // Avoids the hot-join bytes and the dummy descriptor
  function automatic regf_addr_t rand_free_addr();
    regf_addr_t a;
    a = regf_addr_t'(take_bits(REGF_ADDR_W));
    while (a == ADDR_ENEC_BYTE || a == ADDR_DISEC_BYTE ||
           (a >= ADDR_DUMMY_DESC && a < ADDR_DUMMY_DESC + 8))
    begin
      a = regf_addr_t'(take_bits(REGF_ADDR_W));
    end
    return a;
  endfunction

  // ENHJ set only when supported and enabled, DISHJ its inverse
  function automatic void apply_hj_rule();
    logic en;
    en = mirror[ADDR_CRCAP1][0] & mirror[ADDR_HJ_CFG][1];
    mirror[ADDR_ENEC_BYTE][HJ_DEF_BIT]  = en;
    mirror[ADDR_DISEC_BYTE][HJ_DEF_BIT] = ~en;
  endfunction

  function automatic hdr_cmd_t expect_cmd(input regf_addr_t b);
    logic [31:0] w0, w1;
    hdr_cmd_t    c;
    w0 = {mirror[b + 3], mirror[b + 2], mirror[b + 1], mirror[b]};      // Lowest byte first
    w1 = {mirror[b + 7], mirror[b + 6], mirror[b + 5], mirror[b + 4]};
    c  = '0;
    c.data_len  = w1[31:16];
    c.cmd_attr  = w0[2:0];
    c.tid       = w0[6:3];
    c.ccc       = w0[14:7];
    c.cp        = w0[15];
    c.dev_index = w0[20:16];
    c.mode      = w0[28:26];
    {c.toc, c.wroc, c.rnw} = w0[31:29];
    if (w0[0])
    begin
      c.dtt = w0[25:23];               // Immediate layout
    end
    else
    begin
      {c.dbp, c.sre} = w0[25:24];      // Regular layout
    end
    return c;
  endfunction

  function automatic logic [80:0] expect_status();
    crh_regs_t crh;
    ibi_regs_t ibi;
    crh = {mirror[ADDR_CRHDLY], mirror[ADDR_GETSTATUS_LSB], mirror[ADDR_CRCAPS2],
           mirror[ADDR_PRECR], mirror[ADDR_CRH_CFG], mirror[ADDR_TGTS_COUNT]};
    ibi = {mirror[ADDR_IBI_CFG], mirror[ADDR_IBI_PAYLOAD], mirror[ADDR_ARBITRATION]};
    return {crh, ibi, mirror[ADDR_NUM_FRAMES], mirror[ADDR_TARGET][0]};
  endfunction

  task automatic report_mismatch(input string what, input logic [127:0] exp_v,
                                 input logic [127:0] act_v);
    n_errors++;
    $display("CHECK FAILED test %s, %s: expected %0h, actual %0h", test_name, what, exp_v, act_v);
  endtask

  ////////////////////////////////////////
  // Stimulus tasks
  ////////////////////////////////////////
  // Next falling edge, strobes and checks dropped
  task automatic step();
    @(negedge clk);
    rd_en = 1'b0;
    wr_en = 1'b0;
    {chk_rd, chk_cmd, chk_status, chk_hj} = '0;
  endtask

  task automatic write_byte(input regf_addr_t a, input regf_byte_t d);
    step();
    wr_en   = 1'b1;
    addr    = a;
    data_wr = d;
    mirror[a] = d;
    apply_hj_rule();                   // Upkeep lands before any later read
  endtask

  task automatic read_check(input regf_addr_t a);
    regf_byte_t e;
    step();
    rd_en = 1'b1;
    addr  = a;
    e     = mirror[a];
    step();
    exp_rd  = e;                       // Data is out one cycle after the strobe
    last_rd = e;
    chk_rd  = 1'b1;
    n_checks++;
  endtask

  // Both strobes, nothing should move
  task automatic collide(input regf_addr_t a);
    step();
    {rd_en, wr_en} = 2'b11;
    addr    = a;
    data_wr = ~mirror[a];
    step();
    exp_rd = last_rd;
    chk_rd = 1'b1;
    n_checks++;
  endtask

  task automatic check_decode(input regf_addr_t b);
    step();
    base = b;
    step();
    exp_cmd = expect_cmd(b);
    chk_cmd = 1'b1;
    n_checks++;
  endtask

  // Write edge, then copy edge
  task automatic check_status();
    step();
    step();
    exp_status = expect_status();
    chk_status = 1'b1;
    n_checks++;
  endtask

  task automatic check_hj();
    step();
    exp_hj = {mirror[ADDR_HJ_CFG][2:0], mirror[ADDR_CRCAP1][0]};
    chk_hj = 1'b1;
    n_checks++;
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    err_mark  = n_errors;
  endtask

  task automatic end_test();
    step();                            // Lets the last armed check fire
    if (n_errors == err_mark)
    begin
      tests_pass++;
      $display("Test %-10s ok", test_name);
    end
    else
    begin
      tests_fail++;
      $display("Test %-10s FAIL, %0d mismatches", test_name, n_errors - err_mark);
    end
  endtask

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////
  a_read_data : assert property (@(posedge clk) disable iff (!rst_n)
    chk_rd |-> (o_regf_data_rd == exp_rd))
    else report_mismatch("read data", exp_rd, $sampled(o_regf_data_rd));

  a_hdr_cmd : assert property (@(posedge clk) disable iff (!rst_n)
    chk_cmd |-> (o_hdr_cmd == exp_cmd))
    else report_mismatch("hdr command", exp_cmd, $sampled(o_hdr_cmd));

  a_status : assert property (@(posedge clk) disable iff (!rst_n)
    chk_status |-> ({o_crh, o_ibi, o_regf_num_frames, o_ser_rx_tx} == exp_status))
    else report_mismatch("status copies", exp_status,
                         $sampled({o_crh, o_ibi, o_regf_num_frames, o_ser_rx_tx}));

  a_hot_join : assert property (@(posedge clk) disable iff (!rst_n)
    chk_hj |-> ({o_regf_hj_cfg, o_regf_hj_support} == exp_hj))
    else report_mismatch("hot-join outputs", exp_hj,
                         $sampled({o_regf_hj_cfg, o_regf_hj_support}));

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////
  initial
  begin
    regf_addr_t a;
    regf_byte_t d;
    rst_n   = 1'b0;
    {rd_en, wr_en} = 2'b00;
    addr    = '0;
    data_wr = '0;
    base    = '0;
    {chk_rd, chk_cmd, chk_status, chk_hj} = '0;
    lfsr    = 32'h46ee46d5;
    {n_checks, n_errors, tests_pass, tests_fail} = '0;
    for (int i = 0; i < REGF_DEPTH; i++)
    begin
      mirror[i] = regf_default(regf_addr_t'(i));
    end
    apply_hj_rule();                   // First edge out of reset fixes ENHJ/DISHJ

    begin_test("reset");
    repeat (RST_CYCLES) @(negedge clk);
    rst_n = 1'b1;
    step();
    exp_status = expect_status();      // Copies taken at the first edge
    chk_status = 1'b1;
    n_checks++;
    for (int i = 0; i < N_DEF; i++)
    begin
      read_check(DEF_ADDRS[i]);
    end
    end_test();

    begin_test("wr_rd");
    for (int i = 0; i < N_WRRD; i++)
    begin
      a = rand_free_addr();
      write_byte(a, regf_byte_t'(take_bits(8)));
      read_check(a);
    end
    end_test();

    begin_test("collision");
    for (int i = 0; i < N_COLL; i++)
    begin
      read_check(rand_free_addr());
      a = rand_free_addr();
      collide(a);
      read_check(a);                   // Array unchanged
    end
    end_test();

    begin_test("decode");
    for (int r = 0; r < N_DESC; r++)
    begin
      for (int k = 0; k < 8; k++)
      begin
        d = regf_byte_t'(take_bits(8));
        if (k == 0)
        begin
          d[0] = r[0];                 // Alternate immediate and regular
        end
        write_byte(regf_addr_t'(200 + k), d);
      end
      check_decode(regf_addr_t'(200));
    end
    check_decode(ADDR_DUMMY_DESC);
    end_test();

    begin_test("status");
    for (int i = 0; i < N_STATUS; i++)
    begin
      write_byte(STATUS_ADDRS[take_bits(4) % 11], regf_byte_t'(take_bits(8)));
      check_status();
    end
    end_test();

    begin_test("hot_join");
    for (int c = 0; c < 4; c++)
    begin
      d    = regf_byte_t'(take_bits(8));
      d[0] = c[0];                     // Support
      write_byte(ADDR_CRCAP1, d);
      d    = regf_byte_t'(take_bits(8));
      d[1] = c[1];                     // Enable
      write_byte(ADDR_HJ_CFG, d);
      check_hj();
      read_check(ADDR_ENEC_BYTE);
      read_check(ADDR_DISEC_BYTE);
    end
    end_test();

    $display("Summary: %0d tests passed, %0d tests failed, %0d checks, %0d mismatches",
             tests_pass, tests_fail, n_checks, n_errors);
    if (tests_fail == 0 && n_errors == 0)
    begin
      $display("Testbench passed");
    end
    else
    begin
      $display("Testbench failed");
    end
    $finish;
  end

  // Watchdog with a fourfold margin on the cycle budget
  initial
  begin
    #(OPS_TOTAL * CLK_PERIOD * 4);
    $display("Timeout: tests did not finish within %0d clock cycles", OPS_TOTAL * 4);
    $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire
